//--- verilog/axi_burst_pkg.sv
// AXI burst protocol definitions
// Field types and encodings for burst, size, length and response

package axi_burst_pkg;

  // Burst type, AxBURST encoding
  typedef logic [1:0] burst_t;

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  // Bytes per beat as log2, AxSIZE encoding
  typedef logic [2:0] size_t;

  // Number of beats minus one, AxLEN encoding
  typedef logic [7:0] len_t;

  // Response code on B and R
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- verilog/axi_mem_pkg.sv
// AXI memory controller definitions
// Access kind and controller state shared by the datapath blocks

package axi_mem_pkg;

  // Kind of access in progress
  typedef enum logic [1:0] {
    ACC_NONE  = 2'b00,
    ACC_WRITE = 2'b01,
    ACC_READ  = 2'b10
  } acc_kind_t;

  // Controller FSM states
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    WRITE = 2'b01,
    WRESP = 2'b10,
    READ  = 2'b11
  } ctrl_state_t;

endpackage

//--- verilog/axi_mem_array.sv
// Byte-strobed word memory
// Writes strobed bytes at the clock edge, reads combinationally and
// flags addresses beyond the array

`timescale 1ns/1ps

module axi_mem_array #(
  parameter int ADDR_W    = 16,
  parameter int DATA_W    = 32,
  parameter int MEM_WORDS = 256
) (
  input  logic                clk_i,
  input  logic                wr_en_i,
  input  logic [ADDR_W-1:0]   addr_i,
  input  logic [DATA_W-1:0]   wdata_i,
  input  logic [DATA_W/8-1:0] wstrb_i,
  output logic [DATA_W-1:0]   rdata_o,
  output logic                oob_o
);

  localparam int STRB_W = DATA_W / 8;
  localparam int OFF_W  = $clog2(STRB_W);
  localparam int IDX_W  = $clog2(MEM_WORDS);

  logic [DATA_W-1:0]       mem [MEM_WORDS];
  logic [ADDR_W-OFF_W-1:0] word_addr;
  logic [IDX_W-1:0]        idx;

  // Byte offset inside the word is dropped
  assign word_addr = addr_i[ADDR_W-1:OFF_W];
  assign idx       = word_addr[IDX_W-1:0];
  assign oob_o     = (word_addr >= MEM_WORDS);

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign rdata_o = oob_o ? '0 : mem[idx];

endmodule

//--- verilog/axi_beat_counter.sv
// AXI beat counter
// Latches the burst on load, counts beats and derives each beat address
// for FIXED, INCR and WRAP bursts

`timescale 1ns/1ps

module axi_beat_counter
  import axi_burst_pkg::*, axi_mem_pkg::*;
#(
  parameter int ADDR_W = 16
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              load_i,
  input  logic              adv_i,
  input  acc_kind_t         kind_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  len_t              aw_len_i,
  input  size_t             aw_size_i,
  input  burst_t            aw_burst_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  len_t              ar_len_i,
  input  size_t             ar_size_i,
  input  burst_t            ar_burst_i,
  output logic [ADDR_W-1:0] beat_addr_o,
  output len_t              beat_cnt_o,
  output logic              last_beat_o
);

  logic [ADDR_W-1:0] start_q;
  len_t              len_q;
  size_t             size_q;
  burst_t            burst_q;
  len_t              cnt_q;

  logic [ADDR_W-1:0] size_mask, wrap_mask, step_off, next_incr;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_q <= '0;
      len_q   <= '0;
      size_q  <= '0;
      burst_q <= BURST_INCR;
      cnt_q   <= '0;
    end else if (load_i) begin
      cnt_q <= '0;
      if (kind_i == ACC_WRITE) begin
        start_q <= aw_addr_i;
        len_q   <= aw_len_i;
        size_q  <= aw_size_i;
        burst_q <= aw_burst_i;
      end else begin
        start_q <= ar_addr_i;
        len_q   <= ar_len_i;
        size_q  <= ar_size_i;
        burst_q <= ar_burst_i;
      end
    end else if (adv_i) begin
      cnt_q <= cnt_q + 8'd1;
    end
  end

  // Offset of the current beat from the aligned start
  assign size_mask = (ADDR_W'(1) << size_q) - ADDR_W'(1);
  assign step_off  = ADDR_W'(cnt_q) << size_q;
  assign next_incr = (start_q & ~size_mask) + step_off;
  // Window of (len+1) beats, a power of two for legal WRAP lengths
  assign wrap_mask = ((ADDR_W'(len_q) + ADDR_W'(1)) << size_q) - ADDR_W'(1);

  always_comb begin
    case (burst_q)
      BURST_FIXED: beat_addr_o = start_q;
      BURST_WRAP:  beat_addr_o = (start_q & ~wrap_mask) | (next_incr & wrap_mask);
      // First INCR beat keeps an unaligned start address
      default:     beat_addr_o = (cnt_q == '0) ? start_q : next_incr;
    endcase
  end

  assign beat_cnt_o  = cnt_q;
  assign last_beat_o = (cnt_q == len_q);

endmodule

//--- verilog/axi_mem_ctrl.sv
// AXI memory controller
// Serves one burst at a time with write priority, sequences the
// address, data, response and read beats

`timescale 1ns/1ps

module axi_mem_ctrl
  import axi_burst_pkg::*, axi_mem_pkg::*;
#(
  parameter int ID_W = 4
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  // AXI handshakes
  input  logic            aw_valid_i,
  input  logic [ID_W-1:0] aw_id_i,
  input  logic            ar_valid_i,
  input  logic [ID_W-1:0] ar_id_i,
  input  logic            w_valid_i,
  input  logic            b_ready_i,
  input  logic            r_ready_i,
  output logic            aw_ready_o,
  output logic            ar_ready_o,
  output logic            w_ready_o,
  output logic            b_valid_o,
  output logic [ID_W-1:0] b_id_o,
  output resp_t           b_resp_o,
  output logic            r_valid_o,
  output logic [ID_W-1:0] r_id_o,
  output resp_t           r_resp_o,
  output logic            r_last_o,
  // Datapath control
  output logic            cnt_load_o,
  output logic            cnt_adv_o,
  output acc_kind_t       acc_kind_o,
  input  logic            last_beat_i,
  input  logic            oob_i,
  output logic            wr_en_o,
  output logic            beat_fire_o,
  output logic [ID_W-1:0] txn_id_o
);

  ctrl_state_t     state_q, state_d;
  logic [ID_W-1:0] id_q;
  logic            werr_q;
  logic            aw_hs, ar_hs, w_hs, r_hs;

  // Channel readiness follows the state directly
  assign aw_ready_o = (state_q == IDLE);
  assign ar_ready_o = (state_q == IDLE) && !aw_valid_i;
  assign w_ready_o  = (state_q == WRITE);
  assign b_valid_o  = (state_q == WRESP);
  assign r_valid_o  = (state_q == READ);

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign ar_hs = ar_valid_i && ar_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign r_hs  = r_ready_i && r_valid_o;

  assign cnt_load_o  = aw_hs || ar_hs;
  assign cnt_adv_o   = w_hs || r_hs;
  assign beat_fire_o = w_hs || r_hs;
  // Out-of-range write beats are dropped
  assign wr_en_o     = w_hs && !oob_i;

  assign txn_id_o = id_q;
  assign b_id_o   = id_q;
  assign r_id_o   = id_q;
  assign b_resp_o = werr_q ? RESP_SLVERR : RESP_OKAY;
  assign r_resp_o = oob_i ? RESP_SLVERR : RESP_OKAY;
  assign r_last_o = (state_q == READ) && last_beat_i;

  // Access kind, in IDLE it tells the counter which request to load
  always_comb begin
    case (state_q)
      IDLE: begin
        if (aw_valid_i) begin
          acc_kind_o = ACC_WRITE;
        end else if (ar_valid_i) begin
          acc_kind_o = ACC_READ;
        end else begin
          acc_kind_o = ACC_NONE;
        end
      end
      WRITE, WRESP: acc_kind_o = ACC_WRITE;
      default:      acc_kind_o = ACC_READ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (aw_hs) begin
          state_d = WRITE;
        end else if (ar_hs) begin
          state_d = READ;
        end
      end
      WRITE: begin
        // Beat count decides the end of the burst, W last is ignored
        if (w_hs && last_beat_i) begin
          state_d = WRESP;
        end
      end
      WRESP: begin
        if (b_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        if (r_hs && last_beat_i) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      id_q    <= '0;
      werr_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (aw_hs) begin
        id_q   <= aw_id_i;
        werr_q <= 1'b0;
      end else if (ar_hs) begin
        id_q <= ar_id_i;
      end
      // Sticky over the whole write burst
      if (w_hs && oob_i) begin
        werr_q <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/axi_mem_monitor.sv
// AXI memory beat monitor
// Presents each accepted beat on the write or read monitor channel
// one cycle after its handshake

`timescale 1ns/1ps

module axi_mem_monitor
  import axi_burst_pkg::*, axi_mem_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32,
  parameter int ID_W   = 4
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              fire_i,
  input  acc_kind_t         kind_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [DATA_W-1:0] rdata_i,
  input  logic [ID_W-1:0]   id_i,
  input  len_t              beat_cnt_i,
  input  logic              last_i,
  output logic              mon_w_valid_o,
  output logic [ADDR_W-1:0] mon_w_addr_o,
  output logic [DATA_W-1:0] mon_w_data_o,
  output logic [ID_W-1:0]   mon_w_id_o,
  output len_t              mon_w_beat_count_o,
  output logic              mon_w_last_o,
  output logic              mon_r_valid_o,
  output logic [ADDR_W-1:0] mon_r_addr_o,
  output logic [DATA_W-1:0] mon_r_data_o,
  output logic [ID_W-1:0]   mon_r_id_o,
  output len_t              mon_r_beat_count_o,
  output logic              mon_r_last_o
);

  logic w_fire, r_fire;

  assign w_fire = fire_i && (kind_i == ACC_WRITE);
  assign r_fire = fire_i && (kind_i == ACC_READ);

  // Valids are high for exactly one cycle per beat
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mon_w_valid_o <= 1'b0;
      mon_r_valid_o <= 1'b0;
    end else begin
      mon_w_valid_o <= w_fire;
      mon_r_valid_o <= r_fire;
    end
  end

  // Fields hold their last beat between valids
  always_ff @(posedge clk_i) begin
    if (w_fire) begin
      mon_w_addr_o       <= addr_i;
      mon_w_data_o       <= wdata_i;
      mon_w_id_o         <= id_i;
      mon_w_beat_count_o <= beat_cnt_i;
      mon_w_last_o       <= last_i;
    end
    if (r_fire) begin
      mon_r_addr_o       <= addr_i;
      mon_r_data_o       <= rdata_i;
      mon_r_id_o         <= id_i;
      mon_r_beat_count_o <= beat_cnt_i;
      mon_r_last_o       <= last_i;
    end
  end

endmodule

//--- verilog/axi_mem_top.sv
// AXI4 slave memory with monitor port
// Connects the controller, beat counter, memory array and monitor
// and sets the widths and depth

`timescale 1ns/1ps

module axi_mem_top
  import axi_burst_pkg::*, axi_mem_pkg::*;
#(
  parameter int ADDR_W    = 16,
  parameter int DATA_W    = 32,
  parameter int ID_W      = 4,
  parameter int MEM_WORDS = 256
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Write address channel
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  logic [ADDR_W-1:0]   aw_addr_i,
  input  logic [ID_W-1:0]     aw_id_i,
  input  len_t                aw_len_i,
  input  size_t               aw_size_i,
  input  burst_t              aw_burst_i,
  // Write data channel
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  logic [DATA_W-1:0]   w_data_i,
  input  logic [DATA_W/8-1:0] w_strb_i,
  // Write response channel
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output logic [ID_W-1:0]     b_id_o,
  output resp_t               b_resp_o,
  // Read address channel
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  logic [ADDR_W-1:0]   ar_addr_i,
  input  logic [ID_W-1:0]     ar_id_i,
  input  len_t                ar_len_i,
  input  size_t               ar_size_i,
  input  burst_t              ar_burst_i,
  // Read data channel
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output logic [DATA_W-1:0]   r_data_o,
  output logic [ID_W-1:0]     r_id_o,
  output resp_t               r_resp_o,
  output logic                r_last_o,
  // Monitor
  output logic                mon_w_valid_o,
  output logic [ADDR_W-1:0]   mon_w_addr_o,
  output logic [DATA_W-1:0]   mon_w_data_o,
  output logic [ID_W-1:0]     mon_w_id_o,
  output len_t                mon_w_beat_count_o,
  output logic                mon_w_last_o,
  output logic                mon_r_valid_o,
  output logic [ADDR_W-1:0]   mon_r_addr_o,
  output logic [DATA_W-1:0]   mon_r_data_o,
  output logic [ID_W-1:0]     mon_r_id_o,
  output len_t                mon_r_beat_count_o,
  output logic                mon_r_last_o
);

  logic              cnt_load, cnt_adv, last_beat, oob, wr_en, beat_fire;
  acc_kind_t         acc_kind;
  logic [ADDR_W-1:0] beat_addr;
  len_t              beat_cnt;
  logic [DATA_W-1:0] rd_data;
  logic [ID_W-1:0]   txn_id;

  assign r_data_o = rd_data;

  axi_mem_ctrl #(
    .ID_W (ID_W)
  ) axi_mem_ctrl_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .aw_valid_i  (aw_valid_i),
    .aw_id_i     (aw_id_i),
    .ar_valid_i  (ar_valid_i),
    .ar_id_i     (ar_id_i),
    .w_valid_i   (w_valid_i),
    .b_ready_i   (b_ready_i),
    .r_ready_i   (r_ready_i),
    .aw_ready_o  (aw_ready_o),
    .ar_ready_o  (ar_ready_o),
    .w_ready_o   (w_ready_o),
    .b_valid_o   (b_valid_o),
    .b_id_o      (b_id_o),
    .b_resp_o    (b_resp_o),
    .r_valid_o   (r_valid_o),
    .r_id_o      (r_id_o),
    .r_resp_o    (r_resp_o),
    .r_last_o    (r_last_o),
    .cnt_load_o  (cnt_load),
    .cnt_adv_o   (cnt_adv),
    .acc_kind_o  (acc_kind),
    .last_beat_i (last_beat),
    .oob_i       (oob),
    .wr_en_o     (wr_en),
    .beat_fire_o (beat_fire),
    .txn_id_o    (txn_id)
  );

  axi_beat_counter #(
    .ADDR_W (ADDR_W)
  ) axi_beat_counter_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .load_i      (cnt_load),
    .adv_i       (cnt_adv),
    .kind_i      (acc_kind),
    .aw_addr_i   (aw_addr_i),
    .aw_len_i    (aw_len_i),
    .aw_size_i   (aw_size_i),
    .aw_burst_i  (aw_burst_i),
    .ar_addr_i   (ar_addr_i),
    .ar_len_i    (ar_len_i),
    .ar_size_i   (ar_size_i),
    .ar_burst_i  (ar_burst_i),
    .beat_addr_o (beat_addr),
    .beat_cnt_o  (beat_cnt),
    .last_beat_o (last_beat)
  );

  axi_mem_array #(
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W),
    .MEM_WORDS (MEM_WORDS)
  ) axi_mem_array_inst (
    .clk_i   (clk_i),
    .wr_en_i (wr_en),
    .addr_i  (beat_addr),
    .wdata_i (w_data_i),
    .wstrb_i (w_strb_i),
    .rdata_o (rd_data),
    .oob_o   (oob)
  );

  axi_mem_monitor #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W),
    .ID_W   (ID_W)
  ) axi_mem_monitor_inst (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .fire_i             (beat_fire),
    .kind_i             (acc_kind),
    .addr_i             (beat_addr),
    .wdata_i            (w_data_i),
    .rdata_i            (rd_data),
    .id_i               (txn_id),
    .beat_cnt_i         (beat_cnt),
    .last_i             (last_beat),
    .mon_w_valid_o      (mon_w_valid_o),
    .mon_w_addr_o       (mon_w_addr_o),
    .mon_w_data_o       (mon_w_data_o),
    .mon_w_id_o         (mon_w_id_o),
    .mon_w_beat_count_o (mon_w_beat_count_o),
    .mon_w_last_o       (mon_w_last_o),
    .mon_r_valid_o      (mon_r_valid_o),
    .mon_r_addr_o       (mon_r_addr_o),
    .mon_r_data_o       (mon_r_data_o),
    .mon_r_id_o         (mon_r_id_o),
    .mon_r_beat_count_o (mon_r_beat_count_o),
    .mon_r_last_o       (mon_r_last_o)
  );

endmodule

//--- sim/tb_axi_mem_top.sv
// Testbench for the AXI4 slave memory
// Table-driven AXI master with a byte-level reference model,
// checks B and R responses and every monitor beat

`timescale 1ns/1ps

module tb_axi_mem_top
  import axi_burst_pkg::*, axi_mem_pkg::*;
();

  localparam int ADDR_W       = 16;
  localparam int DATA_W       = 32;
  localparam int ID_W         = 4;
  localparam int MEM_WORDS    = 256;
  localparam int STRB_W       = DATA_W / 8;
  localparam int MEM_BYTES    = MEM_WORDS * STRB_W;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TXN      = 14;

  typedef struct packed {
    acc_kind_t         kind;
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    len_t              len;
    size_t             size;
    burst_t            burst;
    logic [STRB_W-1:0] strb;
    logic              err;
  } txn_t;

  typedef struct packed {
    logic              is_read;
    logic [7:0]        entry;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    len_t              cnt;
    logic              last;
  } mon_beat_t;

  logic                clk_i;
  logic                arst_n_i;
  logic                aw_valid_i, aw_ready_o;
  logic [ADDR_W-1:0]   aw_addr_i;
  logic [ID_W-1:0]     aw_id_i;
  len_t                aw_len_i;
  size_t               aw_size_i;
  burst_t              aw_burst_i;
  logic                w_valid_i, w_ready_o;
  logic [DATA_W-1:0]   w_data_i;
  logic [STRB_W-1:0]   w_strb_i;
  logic                b_valid_o, b_ready_i;
  logic [ID_W-1:0]     b_id_o;
  resp_t               b_resp_o;
  logic                ar_valid_i, ar_ready_o;
  logic [ADDR_W-1:0]   ar_addr_i;
  logic [ID_W-1:0]     ar_id_i;
  len_t                ar_len_i;
  size_t               ar_size_i;
  burst_t              ar_burst_i;
  logic                r_valid_o, r_ready_i, r_last_o;
  logic [DATA_W-1:0]   r_data_o;
  logic [ID_W-1:0]     r_id_o;
  resp_t               r_resp_o;
  logic                mon_w_valid_o, mon_w_last_o, mon_r_valid_o, mon_r_last_o;
  logic [ADDR_W-1:0]   mon_w_addr_o, mon_r_addr_o;
  logic [DATA_W-1:0]   mon_w_data_o, mon_r_data_o;
  logic [ID_W-1:0]     mon_w_id_o, mon_r_id_o;
  len_t                mon_w_beat_count_o, mon_r_beat_count_o;

  // Handshakes and response fields captured at the rising edge
  logic aw_hs_q = 1'b0;
  logic ar_hs_q = 1'b0;
  logic w_hs_q  = 1'b0;
  logic b_hs_q  = 1'b0;
  logic r_hs_q  = 1'b0;
  logic [ID_W-1:0]   b_id_q, r_id_q;
  resp_t             b_resp_q, r_resp_q;
  logic [DATA_W-1:0] r_data_q;
  logic              r_last_q;

  txn_t       txns [NUM_TXN];
  string      names [NUM_TXN];
  logic [7:0] ref_mem [MEM_BYTES];
  mon_beat_t  mon_exp_q [$];
  int         mon_count   = 0;
  int         cycle_count = 0;
  int         cycle_limit = 0;
  integer     seed;

  axi_mem_top #(
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W),
    .ID_W      (ID_W),
    .MEM_WORDS (MEM_WORDS)
  ) axi_mem_top_inst (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .aw_valid_i (aw_valid_i), .aw_ready_o (aw_ready_o), .aw_addr_i (aw_addr_i),
    .aw_id_i (aw_id_i), .aw_len_i (aw_len_i), .aw_size_i (aw_size_i),
    .aw_burst_i (aw_burst_i),
    .w_valid_i (w_valid_i), .w_ready_o (w_ready_o), .w_data_i (w_data_i),
    .w_strb_i (w_strb_i),
    .b_valid_o (b_valid_o), .b_ready_i (b_ready_i), .b_id_o (b_id_o),
    .b_resp_o (b_resp_o),
    .ar_valid_i (ar_valid_i), .ar_ready_o (ar_ready_o), .ar_addr_i (ar_addr_i),
    .ar_id_i (ar_id_i), .ar_len_i (ar_len_i), .ar_size_i (ar_size_i),
    .ar_burst_i (ar_burst_i),
    .r_valid_o (r_valid_o), .r_ready_i (r_ready_i), .r_data_o (r_data_o),
    .r_id_o (r_id_o), .r_resp_o (r_resp_o), .r_last_o (r_last_o),
    .mon_w_valid_o (mon_w_valid_o), .mon_w_addr_o (mon_w_addr_o),
    .mon_w_data_o (mon_w_data_o), .mon_w_id_o (mon_w_id_o),
    .mon_w_beat_count_o (mon_w_beat_count_o), .mon_w_last_o (mon_w_last_o),
    .mon_r_valid_o (mon_r_valid_o), .mon_r_addr_o (mon_r_addr_o),
    .mon_r_data_o (mon_r_data_o), .mon_r_id_o (mon_r_id_o),
    .mon_r_beat_count_o (mon_r_beat_count_o), .mon_r_last_o (mon_r_last_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  task automatic set_entry(input int i, input string name, input acc_kind_t kind,
                           input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                           input len_t len, input burst_t burst,
                           input logic [STRB_W-1:0] strb, input logic err);
    names[i] = name;
    txns[i]  = '{kind, addr, id, len, 3'd2, burst, strb, err};
  endtask

  task automatic build_table();
    set_entry(0,  "single write",      ACC_WRITE, 16'h0010, 4'd1,  8'd0, BURST_INCR,  4'hF, 0);
    set_entry(1,  "single read",       ACC_READ,  16'h0010, 4'd2,  8'd0, BURST_INCR,  4'hF, 0);
    set_entry(2,  "incr fill",         ACC_WRITE, 16'h0040, 4'd3,  8'd3, BURST_INCR,  4'hF, 0);
    set_entry(3,  "incr partial",      ACC_WRITE, 16'h0040, 4'd4,  8'd3, BURST_INCR,  4'h5, 0);
    set_entry(4,  "incr readback",     ACC_READ,  16'h0040, 4'd5,  8'd3, BURST_INCR,  4'hF, 0);
    set_entry(5,  "wrap write",        ACC_WRITE, 16'h0088, 4'd6,  8'd3, BURST_WRAP,  4'hF, 0);
    set_entry(6,  "wrap readback",     ACC_READ,  16'h0088, 4'd7,  8'd3, BURST_WRAP,  4'hF, 0);
    set_entry(7,  "fixed write",       ACC_WRITE, 16'h0020, 4'd8,  8'd2, BURST_FIXED, 4'hF, 0);
    set_entry(8,  "fixed readback",    ACC_READ,  16'h0020, 4'd9,  8'd0, BURST_INCR,  4'hF, 0);
    // 0x410 aliases word 4 if the range check were missing
    set_entry(9,  "oob write",         ACC_WRITE, 16'h0410, 4'd10, 8'd0, BURST_INCR,  4'hF, 1);
    set_entry(10, "oob read",          ACC_READ,  16'h0410, 4'd11, 8'd0, BURST_INCR,  4'hF, 1);
    set_entry(11, "post oob readback", ACC_READ,  16'h0010, 4'd12, 8'd0, BURST_INCR,  4'hF, 0);
    set_entry(12, "edge write",        ACC_WRITE, 16'h03F8, 4'd13, 8'd3, BURST_INCR,  4'hF, 1);
    set_entry(13, "edge read",         ACC_READ,  16'h03F8, 4'd14, 8'd3, BURST_INCR,  4'hF, 1);
  endtask

  function automatic logic random_ready();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // Distinct bytes per entry and beat so merges and overwrites show up
  function automatic logic [DATA_W-1:0] beat_data(input int e, input int beat);
    return {8'(e + 16), 8'(beat * 17 + e * 5 + 3), 8'(e * 29 + beat), 8'hC3 ^ 8'(e * 8 + beat)};
  endfunction

  // Burst address rule, linear beat position folded into the wrap window
  function automatic logic [ADDR_W-1:0] beat_address(input logic [ADDR_W-1:0] start,
                                                     input len_t len, input size_t size,
                                                     input burst_t burst, input int beat);
    int nbytes;
    int lin;
    int wbytes;
    int base;
    nbytes = 1 << size;
    lin    = (int'(start) / nbytes) * nbytes + beat * nbytes;
    wbytes = (int'(len) + 1) * nbytes;
    base   = (int'(start) / wbytes) * wbytes;
    case (burst)
      BURST_FIXED: return start;
      BURST_WRAP:  return ADDR_W'(base + (lin - base) % wbytes);
      default:     return (beat == 0) ? start : ADDR_W'(lin);
    endcase
  endfunction

  function automatic logic in_range(input logic [ADDR_W-1:0] addr);
    return int'(addr) < MEM_BYTES;
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
    int base;
    base = (int'(addr) / STRB_W) * STRB_W;
    if (in_range(addr)) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) begin
          ref_mem[base + b] = data[b*8 +: 8];
        end
      end
    end
  endtask

  // Only bytes written earlier in the table are ever read back
  function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] word;
    int                base;
    word = '0;
    base = (int'(addr) / STRB_W) * STRB_W;
    if (in_range(addr)) begin
      for (int b = 0; b < STRB_W; b++) begin
        word[b*8 +: 8] = ref_mem[base + b];
      end
    end
    return word;
  endfunction

  task automatic run_write(input int e);
    txn_t              t;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    t = txns[e];
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_addr_i  = t.addr;
    aw_id_i    = t.id;
    aw_len_i   = t.len;
    aw_size_i  = t.size;
    aw_burst_i = t.burst;
    do begin
      @(negedge clk_i);
    end while (!aw_hs_q);
    aw_valid_i = 1'b0;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      a = beat_address(t.addr, t.len, t.size, t.burst, beat);
      d = beat_data(e, beat);
      w_valid_i = 1'b1;
      w_data_i  = d;
      w_strb_i  = t.strb;
      mon_exp_q.push_back('{1'b0, 8'(e), a, d, t.id, len_t'(beat), beat == int'(t.len)});
      do begin
        @(negedge clk_i);
      end while (!w_hs_q);
      model_write(a, d, t.strb);
    end
    w_valid_i = 1'b0;
    do begin
      b_ready_i = random_ready();
      @(negedge clk_i);
    end while (!b_hs_q);
    b_ready_i = 1'b0;
    check_value({names[e], " b_id"}, t.id, b_id_q);
    check_value({names[e], " b_resp"}, t.err ? RESP_SLVERR : RESP_OKAY, b_resp_q);
  endtask

  task automatic run_read(input int e);
    txn_t              t;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic              saw_err;
    t       = txns[e];
    saw_err = 1'b0;
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_addr_i  = t.addr;
    ar_id_i    = t.id;
    ar_len_i   = t.len;
    ar_size_i  = t.size;
    ar_burst_i = t.burst;
    do begin
      @(negedge clk_i);
    end while (!ar_hs_q);
    ar_valid_i = 1'b0;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      a = beat_address(t.addr, t.len, t.size, t.burst, beat);
      d = model_read(a);
      mon_exp_q.push_back('{1'b1, 8'(e), a, d, t.id, len_t'(beat), beat == int'(t.len)});
      do begin
        r_ready_i = random_ready();
        @(negedge clk_i);
      end while (!r_hs_q);
      check_value($sformatf("%s beat %0d r_data", names[e], beat), d, r_data_q);
      check_value($sformatf("%s beat %0d r_id", names[e], beat), t.id, r_id_q);
      check_value($sformatf("%s beat %0d r_resp", names[e], beat),
                  in_range(a) ? RESP_OKAY : RESP_SLVERR, r_resp_q);
      check_value($sformatf("%s beat %0d r_last", names[e], beat),
                  beat == int'(t.len), r_last_q);
      saw_err = saw_err | (r_resp_q == RESP_SLVERR);
    end
    r_ready_i = 1'b0;
    check_value({names[e], " error seen"}, t.err, saw_err);
  endtask

  always @(posedge clk_i) begin
    aw_hs_q <= aw_valid_i && aw_ready_o;
    ar_hs_q <= ar_valid_i && ar_ready_o;
    w_hs_q  <= w_valid_i && w_ready_o;
    b_hs_q  <= b_valid_o && b_ready_i;
    r_hs_q  <= r_valid_o && r_ready_i;
    if (b_valid_o && b_ready_i) begin
      b_id_q   <= b_id_o;
      b_resp_q <= b_resp_o;
    end
    if (r_valid_o && r_ready_i) begin
      r_data_q <= r_data_o;
      r_id_q   <= r_id_o;
      r_resp_q <= r_resp_o;
      r_last_q <= r_last_o;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      abort_run($sformatf("Timeout: run did not complete within %0d cycles", cycle_limit));
    end
  end

  // Monitor beats are compared in order with the beats the master issued
  always @(negedge clk_i) begin
    mon_beat_t exp_beat;
    string     tag;
    if (mon_w_valid_o && mon_r_valid_o) begin
      abort_run("Both monitor channels were valid in the same cycle");
    end else if (mon_w_valid_o || mon_r_valid_o) begin
      if (mon_exp_q.size() == 0) begin
        abort_run("Monitor reported a beat that no transaction produced");
      end else begin
        exp_beat = mon_exp_q.pop_front();
        mon_count++;
        tag = $sformatf("%s mon beat %0d", names[exp_beat.entry], exp_beat.cnt);
        check_value({tag, " channel"}, exp_beat.is_read, mon_r_valid_o);
        if (mon_w_valid_o) begin
          check_value({tag, " addr"}, exp_beat.addr, mon_w_addr_o);
          check_value({tag, " data"}, exp_beat.data, mon_w_data_o);
          check_value({tag, " id"}, exp_beat.id, mon_w_id_o);
          check_value({tag, " count"}, exp_beat.cnt, mon_w_beat_count_o);
          check_value({tag, " last"}, exp_beat.last, mon_w_last_o);
        end else begin
          check_value({tag, " addr"}, exp_beat.addr, mon_r_addr_o);
          check_value({tag, " data"}, exp_beat.data, mon_r_data_o);
          check_value({tag, " id"}, exp_beat.id, mon_r_id_o);
          check_value({tag, " count"}, exp_beat.cnt, mon_r_beat_count_o);
          check_value({tag, " last"}, exp_beat.last, mon_r_last_o);
        end
      end
    end
  end

  initial begin
    int total_beats;
    seed       = 78063;
    arst_n_i   = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    aw_len_i   = '0;
    aw_size_i  = '0;
    aw_burst_i = BURST_INCR;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    ar_len_i   = '0;
    ar_size_i  = '0;
    ar_burst_i = BURST_INCR;
    r_ready_i  = 1'b0;
    build_table();
    // Address, beats and response, four cycles of slack for each
    total_beats = 0;
    cycle_limit = RESET_CYCLES;
    for (int i = 0; i < NUM_TXN; i++) begin
      cycle_limit += (int'(txns[i].len) + 3) * 4;
      total_beats += int'(txns[i].len) + 1;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    arst_n_i = 1'b1;
    for (int e = 0; e < NUM_TXN; e++) begin
      if (txns[e].kind == ACC_WRITE) begin
        run_write(e);
      end else begin
        run_read(e);
      end
    end
    // Let the final monitor beat land
    @(negedge clk_i);
    check_value("monitor beat total", total_beats, mon_count);
    check_value("monitor beats left over", 0, mon_exp_q.size());
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- files.f
verilog/axi_burst_pkg.sv
verilog/axi_mem_pkg.sv
verilog/axi_mem_array.sv
verilog/axi_beat_counter.sv
verilog/axi_mem_ctrl.sv
verilog/axi_mem_monitor.sv
verilog/axi_mem_top.sv
sim/tb_axi_mem_top.sv

//--- Makefile
# Verilator build and run for the AXI4 slave memory

VERILATOR ?= verilator
TOP       ?= tb_axi_mem_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS
BIN       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
